// ==== Makefile ====
SOURCES := $(wildcard rtl/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vtb_div_top: verilog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_div_top

run: obj_dir/Vtb_div_top
	./obj_dir/Vtb_div_top | tee sim.log
	grep -qx "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module div_top

clean:
	rm -rf obj_dir sim.log

// ==== rtl/div_ctrl_fsm.sv ====
`timescale 1ns/1ps

module div_ctrl_fsm
    import div_fsm_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic en,
    input  logic flush,
    input  logic early_exit,
    input  logic last_step,
    output logic capture,
    output logic load,
    output logic step,
    output logic commit,
    output logic clear,
    output logic busy,
    output logic ready
);

    div_state_t state;
    div_state_t state_next;

    // flush drops any division in flight
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (en) begin
                    state_next = st_check;
                end
            end
            // zero divisor or too many divisor digits skips the loop
            st_check: state_next = early_exit ? st_fix : st_calc;
            st_calc: begin
                if (last_step) begin
                    state_next = st_fix;
                end
            end
            st_fix:  state_next = st_done;
            st_done: state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    // strobes decoded straight from the state
    assign capture = (state == st_idle) && en && !flush;
    assign load    = (state == st_check);
    assign step    = (state == st_calc);
    assign commit  = (state == st_fix);
    assign clear   = (state == st_done) || flush;
    assign busy    = (state != st_idle);
    assign ready   = (state == st_done);

    a_ready_busy: assert property (@(posedge clk) disable iff (!rstn)
        ready |-> busy);

    // single-cycle result pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ready |=> !ready);

endmodule

// ==== rtl/div_fsm_pkg.sv ====
package div_fsm_pkg;

    // control states of one division
    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_check = 3'd1,
        st_calc  = 3'd2,
        st_fix   = 3'd3,
        st_done  = 3'd4
    } div_state_t;

endpackage

// ==== rtl/div_operand_prep.sv ====
`timescale 1ns/1ps

module div_operand_prep
    import div_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   flush,
    input  logic   capture,
    input  logic   is_signed,
    input  data_t  dividend,
    input  data_t  divisor,
    output data_t  dividend_mag,
    output work_t  divisor_aligned,
    output digit_t step_count,
    output logic   early_exit,
    output logic   neg_quotient,
    output logic   neg_remainder
);

    logic   dividend_neg;
    logic   divisor_neg;
    data_t  dividend_abs;
    data_t  divisor_abs;

    data_t  dividend_mag_q;
    data_t  divisor_mag_q;
    logic   dividend_neg_q;
    logic   divisor_neg_q;
    digit_t dividend_digits_q;
    digit_t divisor_digits_q;

    // sign bits only count for signed division
    assign dividend_neg = is_signed && dividend[data_w-1];
    assign divisor_neg  = is_signed && divisor[data_w-1];
    assign dividend_abs = dividend_neg ? -dividend : dividend;
    assign divisor_abs  = divisor_neg ? -divisor : divisor;

    always_ff @(posedge clk) begin
        if (capture) begin
            dividend_mag_q <= dividend_abs;
            divisor_mag_q  <= divisor_abs;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            dividend_neg_q    <= 1'b0;
            divisor_neg_q     <= 1'b0;
            dividend_digits_q <= '0;
            divisor_digits_q  <= '0;
        end else if (capture) begin
            dividend_neg_q    <= dividend_neg;
            divisor_neg_q     <= divisor_neg;
            dividend_digits_q <= leading_digits(dividend_abs);
            divisor_digits_q  <= leading_digits(divisor_abs);
        end
    end

    assign early_exit = (divisor_digits_q == '0) || (divisor_digits_q > dividend_digits_q);

    // one quotient bit per digit of difference, plus one
    assign step_count = dividend_digits_q - divisor_digits_q + digit_t'(1);

    // top divisor digit lines up with top dividend digit
    assign divisor_aligned = work_t'(divisor_mag_q) << (step_count - digit_t'(1));

    assign dividend_mag  = dividend_mag_q;
    assign neg_quotient  = dividend_neg_q ^ divisor_neg_q;
    assign neg_remainder = dividend_neg_q;

endmodule

// ==== rtl/div_pkg.sv ====
package div_pkg;

    // operand and result width
    localparam int data_w  = 32;
    // digit count runs 0 to 32
    localparam int digit_w = 6;
    // working remainder and aligned divisor
    localparam int work_w  = 64;

    typedef logic [data_w-1:0]  data_t;
    typedef logic [digit_w-1:0] digit_t;
    typedef logic [work_w-1:0]  work_t;

    // 1-based position of the highest set bit, 0 for a zero word
    function automatic digit_t leading_digits(input data_t value);
        digit_t pos;
        pos = '0;
        for (int i = 0; i < data_w; i++) begin
            if (value[i]) begin
                pos = digit_t'(i + 1);
            end
        end
        return pos;
    endfunction

endpackage

// ==== rtl/div_shift_subtract.sv ====
`timescale 1ns/1ps

module div_shift_subtract
    import div_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  logic  load,
    input  logic  step,
    input  logic  commit,
    input  logic  clear,
    input  logic  neg_quotient,
    input  logic  neg_remainder,
    input  data_t dividend_mag,
    input  work_t divisor_aligned,
    output data_t quotient,
    output data_t remainder
);

    work_t rem_work;
    work_t div_work;
    data_t quot_work;
    logic  take;
    work_t rem_diff;
    data_t rem_low;

    // restoring step: subtract only when it does not borrow
    assign take     = (rem_work >= div_work);
    assign rem_diff = rem_work - div_work;
    assign rem_low  = rem_work[data_w-1:0];

    always_ff @(posedge clk) begin
        if (load) begin
            rem_work <= work_t'(dividend_mag);
            div_work <= divisor_aligned;
        end else if (step) begin
            if (take) begin
                rem_work <= rem_diff;
            end
            div_work <= div_work >> 1;
        end
    end

    // partial quotient is dropped on flush
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            quot_work <= '0;
        end else if (load) begin
            quot_work <= '0;
        end else if (step) begin
            quot_work <= {quot_work[data_w-2:0], take};
        end
    end

    // results only show while ready is up
    always_ff @(posedge clk) begin
        if (!rstn || clear) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (commit) begin
            // truncation toward zero, remainder follows the dividend sign
            quotient  <= neg_quotient ? -quot_work : quot_work;
            remainder <= neg_remainder ? -rem_low : rem_low;
        end
    end

endmodule

// ==== rtl/div_step_counter.sv ====
`timescale 1ns/1ps

module div_step_counter
    import div_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   flush,
    input  logic   load,
    input  logic   step,
    input  digit_t step_count,
    output logic   last_step
);

    // shift-subtract steps still to run
    digit_t remaining;

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= step_count;
        end else if (step) begin
            remaining <= remaining - digit_t'(1);
        end
    end

    assign last_step = (remaining == digit_t'(1));

    // FSM must leave calc before the count runs out
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn || flush)
        step |-> (remaining != '0));

endmodule

// ==== rtl/div_top.sv ====
`timescale 1ns/1ps

module div_top
    import div_pkg::*, div_fsm_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  en,
    input  logic  flush,
    input  logic  is_signed,
    input  data_t dividend,
    input  data_t divisor,
    output data_t quotient,
    output data_t remainder,
    output logic  busy,
    output logic  ready
);

    logic   capture;
    logic   load;
    logic   step;
    logic   commit;
    logic   clear;
    logic   early_exit;
    logic   last_step;
    logic   neg_quotient;
    logic   neg_remainder;
    digit_t step_count;
    data_t  dividend_mag;
    work_t  divisor_aligned;

    div_ctrl_fsm u_fsm (
        .clk        (clk),
        .rstn       (rstn),
        .en         (en),
        .flush      (flush),
        .early_exit (early_exit),
        .last_step  (last_step),
        .capture    (capture),
        .load       (load),
        .step       (step),
        .commit     (commit),
        .clear      (clear),
        .busy       (busy),
        .ready      (ready)
    );

    div_operand_prep u_prep (
        .clk             (clk),
        .rstn            (rstn),
        .flush           (flush),
        .capture         (capture),
        .is_signed       (is_signed),
        .dividend        (dividend),
        .divisor         (divisor),
        .dividend_mag    (dividend_mag),
        .divisor_aligned (divisor_aligned),
        .step_count      (step_count),
        .early_exit      (early_exit),
        .neg_quotient    (neg_quotient),
        .neg_remainder   (neg_remainder)
    );

    div_step_counter u_counter (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .load       (load),
        .step       (step),
        .step_count (step_count),
        .last_step  (last_step)
    );

    div_shift_subtract u_datapath (
        .clk             (clk),
        .rstn            (rstn),
        .flush           (flush),
        .load            (load),
        .step            (step),
        .commit          (commit),
        .clear           (clear),
        .neg_quotient    (neg_quotient),
        .neg_remainder   (neg_remainder),
        .dividend_mag    (dividend_mag),
        .divisor_aligned (divisor_aligned),
        .quotient        (quotient),
        .remainder       (remainder)
    );

    // flush leaves control and datapath idle and zeroed on the next edge
    a_flush_idle: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> (u_fsm.state == st_idle) && !ready && (quotient == '0)
                  && (remainder == '0));

endmodule

// ==== sim/tb_div_top.sv ====
`timescale 1ns/1ps

module tb_div_top;

    localparam int max_wait = 50;

    logic        clk;
    logic        rstn;
    logic        en;
    logic        flush;
    logic        is_signed;
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic        busy;
    logic        ready;

    // test table as parallel queues indexed by row
    string       t_name[$];
    logic        t_signed[$];
    logic [31:0] t_dividend[$];
    logic [31:0] t_divisor[$];
    int          t_flush_at[$];
    logic [31:0] t_quot[$];
    logic [31:0] t_rem[$];

    int          value_errors;
    int          other_errors;
    logic [31:0] rng_state;

    div_top u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .en        (en),
        .flush     (flush),
        .is_signed (is_signed),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (busy),
        .ready     (ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int bit_length(input logic [31:0] v);
        logic [31:0] w;
        int          n;
        w = v;
        n = 0;
        while (w != 32'd0) begin
            w = w >> 1;
            n++;
        end
        return n;
    endfunction

    // edges from the start edge until ready shows
    function automatic int expected_latency(input logic s, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] ma;
        logic [31:0] mb;
        int          da;
        int          db;
        ma = (s && a[31]) ? -a : a;
        mb = (s && b[31]) ? -b : b;
        da = bit_length(ma);
        db = bit_length(mb);
        if (db == 0 || db > da) begin
            return 3;
        end
        return 4 + da - db;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic add_row(input string name, input logic s, input logic [31:0] a,
                           input logic [31:0] b, input int flush_at,
                           input logic [31:0] q, input logic [31:0] r);
        t_name.push_back(name);
        t_signed.push_back(s);
        t_dividend.push_back(a);
        t_divisor.push_back(b);
        t_flush_at.push_back(flush_at);
        t_quot.push_back(q);
        t_rem.push_back(r);
    endtask

    task automatic add_random_row(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        logic [31:0] q;
        logic [31:0] r;
        logic        s;
        rng_state = xorshift(rng_state);
        a = rng_state;
        rng_state = xorshift(rng_state);
        b = rng_state;
        rng_state = xorshift(rng_state);
        sel = rng_state;
        s = sel[0];
        // short divisors give long step counts
        b = b >> sel[12:8];
        if (sel[7:4] == 4'd0) begin
            b = 32'd0;
        end
        if (b == 32'd0) begin
            q = 32'd0;
            r = a;
        end else if (s && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = 32'd0;
        end else if (s) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        add_row($sformatf("random_%0d", idx), s, a, b, 0, q, r);
    endtask

    task automatic build_table();
        add_row("udiv_basic", 1'b0, 32'd100, 32'd7, 0, 32'd14, 32'd2);
        add_row("udiv_max_by_one", 1'b0, 32'hffff_ffff, 32'd1, 0, 32'hffff_ffff, 32'd0);
        add_row("udiv_max_by_16", 1'b0, 32'hffff_ffff, 32'h10, 0, 32'h0fff_ffff, 32'hf);
        add_row("udiv_top_bit", 1'b0, 32'h8000_0000, 32'd3, 0, 32'h2aaa_aaaa, 32'd2);
        add_row("sdiv_pos_pos", 1'b1, 32'd7, 32'd2, 0, 32'd3, 32'd1);
        add_row("sdiv_neg_pos", 1'b1, 32'hffff_fff9, 32'd2, 0, 32'hffff_fffd, 32'hffff_ffff);
        add_row("sdiv_pos_neg", 1'b1, 32'd7, 32'hffff_fffe, 0, 32'hffff_fffd, 32'd1);
        add_row("sdiv_neg_neg", 1'b1, 32'hffff_fff9, 32'hffff_fffe, 0, 32'd3, 32'hffff_ffff);
        add_row("sdiv_min_by_m1", 1'b1, 32'h8000_0000, 32'hffff_ffff, 0, 32'h8000_0000, 32'd0);
        add_row("sdiv_min_by_one", 1'b1, 32'h8000_0000, 32'd1, 0, 32'h8000_0000, 32'd0);
        add_row("early_larger", 1'b0, 32'd5, 32'd9, 0, 32'd0, 32'd5);
        add_row("early_zero", 1'b0, 32'h1234, 32'd0, 0, 32'd0, 32'h1234);
        add_row("early_zero_signed", 1'b1, 32'hffff_fff9, 32'd0, 0, 32'd0, 32'hffff_fff9);
        add_row("flush_mid", 1'b0, 32'hffff_ffff, 32'd1, 6, 32'd0, 32'd0);
        // flush lands on the commit edge of an early exit
        add_row("flush_in_fix", 1'b0, 32'd5, 32'd9, 2, 32'd0, 32'd0);
        add_row("after_flush", 1'b0, 32'd1000, 32'd10, 0, 32'd100, 32'd0);
        for (int i = 0; i < 200; i++) begin
            add_random_row(i);
        end
    endtask

    // start pulse followed by a stray start that busy must block
    task automatic start_division(input int i);
        en        = 1'b1;
        is_signed = t_signed[i];
        dividend  = t_dividend[i];
        divisor   = t_divisor[i];
        next_cycle();
        check_value({t_name[i], " busy"}, 32'd1, 32'(busy));
        dividend  = ~t_dividend[i];
        divisor   = t_divisor[i] ^ 32'h0000_0005;
        next_cycle();
        en        = 1'b0;
    endtask

    task automatic run_complete(input int i);
        int cycles;
        bit seen;
        start_division(i);
        cycles = 2;
        seen   = 1'b0;
        while (!seen && cycles <= max_wait) begin
            check_value({t_name[i], " busy"}, 32'd1, 32'(busy));
            if (ready) begin
                seen = 1'b1;
            end else begin
                check_value({t_name[i], " quotient before ready"}, 32'd0, quotient);
                check_value({t_name[i], " remainder before ready"}, 32'd0, remainder);
                next_cycle();
                cycles++;
            end
        end
        if (!seen) begin
            other_errors++;
            $display("ERROR: %s timed out after %0d cycles waiting for ready",
                     t_name[i], max_wait);
            // abandon the stuck division before the next row
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
        end else begin
            check_value({t_name[i], " quotient"}, t_quot[i], quotient);
            check_value({t_name[i], " remainder"}, t_rem[i], remainder);
            check_value({t_name[i], " latency"},
                        32'(expected_latency(t_signed[i], t_dividend[i], t_divisor[i])),
                        32'(cycles));
            next_cycle();
            check_value({t_name[i], " ready after pulse"}, 32'd0, 32'(ready));
            check_value({t_name[i], " busy after ready"}, 32'd0, 32'(busy));
            check_value({t_name[i], " quotient after ready"}, 32'd0, quotient);
            check_value({t_name[i], " remainder after ready"}, 32'd0, remainder);
        end
    endtask

    task automatic run_flushed(input int i);
        int cycles;
        bit late_ready;
        start_division(i);
        cycles = 2;
        while (cycles < t_flush_at[i] && cycles <= max_wait) begin
            next_cycle();
            cycles++;
        end
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_value({t_name[i], " busy after flush"}, 32'd0, 32'(busy));
        check_value({t_name[i], " ready after flush"}, 32'd0, 32'(ready));
        check_value({t_name[i], " quotient after flush"}, t_quot[i], quotient);
        check_value({t_name[i], " remainder after flush"}, t_rem[i], remainder);
        // the abandoned division must never report a result
        cycles     = 0;
        late_ready = 1'b0;
        while (!late_ready && cycles < max_wait) begin
            if (ready) begin
                late_ready = 1'b1;
                other_errors++;
                $display("ERROR: %s raised ready after the division was flushed", t_name[i]);
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        en           = 1'b0;
        flush        = 1'b0;
        is_signed    = 1'b0;
        dividend     = 32'd0;
        divisor      = 32'd0;
        value_errors = 0;
        other_errors = 0;
        rng_state    = 32'h35e36e44;
        build_table();
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        next_cycle();
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset ready", 32'd0, 32'(ready));
        check_value("reset quotient", 32'd0, quotient);
        check_value("reset remainder", 32'd0, remainder);
        for (int i = 0; i < t_name.size(); i++) begin
            if (t_flush_at[i] != 0) begin
                run_flushed(i);
            end else begin
                run_complete(i);
            end
        end
        $display("rows run: %0d, value errors: %0d, other errors: %0d",
                 t_name.size(), value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/div_pkg.sv
rtl/div_fsm_pkg.sv
rtl/div_ctrl_fsm.sv
rtl/div_step_counter.sv
rtl/div_operand_prep.sv
rtl/div_shift_subtract.sv
rtl/div_top.sv
sim/tb_div_top.sv
